// ==== vlog.f ====
+incdir+verilog
verilog/cpu_types_pkg.sv
verilog/stageReg.sv
verilog/branchUnit.sv
verilog/jumpUnit.sv
verilog/programCounter.sv
verilog/fetchStage.sv
verification/fetchStage_checker.sv
verification/fetchStage_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

# assertions stay on so the bound checker is live
verilator --binary --timing --assert \
	-f vlog.f \
	--top-module fetchStage_tb \
	-Mdir obj_dir \
	-o fetchStage_sim

# a $fatal or a failed assertion ends with a nonzero status
./obj_dir/fetchStage_sim

// ==== verification/fetchStage_tb.sv ====
// random fetch test; memory is an address hash with one halt word, halt is forced by a jr if not hit
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetchStage_tb import cpu_types_pkg::*; ();

	localparam int WARMUP_CYCLES = 40;   // sequential only and below the halt address
	localparam int RANDOM_CYCLES = 2000;
	localparam int HALT_TIMEOUT  = 40;
	localparam int HELD_CYCLES   = 30;

	logic       CLK;
	logic       rstN;
	word_t      imemload;
	logic       exValid;
	xferClass_t exClass;
	word_t      exPC, exInstr, rdat1, rdat2;
	word_t      imemaddr, ifidInstr, ifidPC;
	logic       ifidValid, redirect, halted;

	logic [15:0] lfsrState;
	word_t       haltAddr;  // only address holding the halt word
	word_t       memKey;
	int          redirectCount;
	int          cycleCount;
	int          waitCount;

	// reference state as it stands after the last edge
	word_t      mPc, mIfidInstr, mIfidPC;
	logic       mHalted, mIfidValid, mLatValid;
	xferClass_t mLatClass;
	word_t      mLatPC, mLatInstr, mLatR1, mLatR2;

	fetchStage u_dut (
		.CLK       (CLK),
		.rstN      (rstN),
		.imemload  (imemload),
		.exValid   (exValid),
		.exClass   (exClass),
		.exPC      (exPC),
		.exInstr   (exInstr),
		.rdat1     (rdat1),
		.rdat2     (rdat2),
		.imemaddr  (imemaddr),
		.ifidInstr (ifidInstr),
		.ifidPC    (ifidPC),
		.ifidValid (ifidValid),
		.redirect  (redirect),
		.halted    (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK; // 20 ns period
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic word_t randBits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState); // one step per bit
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// instruction memory contents
	function automatic word_t wordAt(input word_t addr);
		word_t w;
		w = (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ memKey;
		if (addr == haltAddr) begin
			w = `HALT_WORD;
		end else if (w == `HALT_WORD) begin
			w = 32'h0; // halt word stays unique
		end
		return w;
	endfunction

	task automatic checkEqual(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("error at %0.1f ns: %s is %h, expected %h", $realtime, what, actual,
				expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// redirect and target of the latched op
	task automatic modelComb(output logic red, output word_t tgt);
		logic  taken;
		word_t seqPC;
		word_t branchTgt;
		seqPC     = mLatPC + `PC_STEP;
		branchTgt = seqPC + {{14{mLatInstr[15]}}, mLatInstr[15:0], 2'b00};
		taken     = 1'b0;
		tgt       = mLatR1;
		case (mLatClass)
			XFER_BEQ: begin
				taken = (mLatR1 == mLatR2);
				tgt   = branchTgt;
			end
			XFER_BNE: begin
				taken = (mLatR1 != mLatR2);
				tgt   = branchTgt;
			end
			XFER_J: begin
				taken = 1'b1;
				tgt   = {seqPC[31:28], mLatInstr[25:0], 2'b00}; // region of pc+4
			end
			XFER_JR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		red = mLatValid && taken && !mHalted; // nothing redirects once halted
	endtask

	// one rising edge of the reference
	task automatic modelEdge();
		logic  red;
		word_t tgt;
		word_t fetched;
		modelComb(red, tgt);
		fetched = wordAt(mPc);
		if (red) begin
			mIfidValid = 1'b0; // flushed
		end else if (!mHalted && fetched != `HALT_WORD) begin
			mIfidValid = 1'b1;
			mIfidInstr = fetched;
			mIfidPC    = mPc;
		end
		if (red) begin
			mPc = tgt;
			redirectCount++;
		end else if (!mHalted && fetched == `HALT_WORD) begin
			mHalted = 1'b1; // pc holds on the halt word
		end else if (!mHalted) begin
			mPc = mPc + `PC_STEP;
		end
		mLatValid = exValid; // latch lives one cycle per strobe
		if (exValid) begin
			mLatClass = exClass;
			mLatPC    = exPC;
			mLatInstr = exInstr;
			mLatR1    = rdat1;
			mLatR2    = rdat2;
		end
	endtask

	task automatic checkOutputs();
		logic  red;
		word_t tgt;
		modelComb(red, tgt);
		checkEqual(imemaddr, mPc, "imemaddr");
		checkEqual(word_t'(redirect), word_t'(red), "redirect");
		checkEqual(word_t'(halted), word_t'(mHalted), "halted");
		checkEqual(word_t'(ifidValid), word_t'(mIfidValid), "ifidValid");
		if (mIfidValid) begin
			checkEqual(ifidInstr, mIfidInstr, "ifidInstr");
			checkEqual(ifidPC, mIfidPC, "ifidPC");
		end
	endtask

	// drive at the rising edge and check at the falling edge
	task automatic runCycle(input logic strobe, input xferClass_t cls, input word_t pcV,
		input word_t instrV, input word_t r1, input word_t r2);
		@(posedge CLK);
		modelEdge();
		exValid  <= strobe;
		exClass  <= cls;
		exPC     <= pcV;
		exInstr  <= instrV;
		rdat1    <= r1;
		rdat2    <= r2;
		imemload <= wordAt(mPc); // word at the new pc
		@(negedge CLK);
		checkOutputs();
	endtask

	task automatic randomCycle();
		word_t pick, pcV, instrV, r1, r2, lo;
		if (randBits(2) != 0) begin
			runCycle(1'b0, XFER_NONE, '0, '0, '0, '0); // about three in four idle
		end else begin
			pick = randBits(3);
			if (pick > 4) begin
				pick = pick - 4; // fold 5..7 onto 1..3
			end
			pcV = (randBits(4) << 28) | (randBits(10) << 2); // any region, 4 KB window
			if (randBits(3) == 0) begin
				pcV = pcV | 32'h0FFF_FFFC; // last word of a region, pc+4 crosses it
			end
			lo  = randBits(7);
			if (lo[6]) begin
				lo = lo | 32'h0000_FF80; // negative offset
			end
			instrV = (randBits(16) << 16) | lo; // opcode and upper index bits
			r1     = randBits(10) << 2;
			if (randBits(1) == 1) begin
				r2 = r1;
			end else begin
				r2 = randBits(10) << 2;
			end
			runCycle(1'b1, xferClass_t'(pick[2:0]), pcV, instrV, r1, r2);
		end
	endtask

	initial begin
		lfsrState = 16'd37697;
		haltAddr  = 32'h100 + (randBits(9) << 2); // past the warm-up run
		memKey    = randBits(32);
		rstN      = 1'b0;
		exValid   = 1'b0;
		exClass   = XFER_NONE;
		exPC      = '0;
		exInstr   = '0;
		rdat1     = '0;
		rdat2     = '0;
		imemload  = wordAt(`RESET_PC);
		mPc        = `RESET_PC;
		mHalted    = 1'b0;
		mIfidValid = 1'b0;
		mIfidInstr = '0;
		mIfidPC    = '0;
		mLatValid  = 1'b0;
		mLatClass  = XFER_NONE;
		mLatPC     = '0;
		mLatInstr  = '0;
		mLatR1     = '0;
		mLatR2     = '0;
		redirectCount = 0;
		repeat (5) @(posedge CLK);
		rstN <= 1'b1;
		@(negedge CLK);
		checkOutputs(); // reset values

		for (int i = 0; i < WARMUP_CYCLES; i++) begin
			runCycle(1'b0, XFER_NONE, '0, '0, '0, '0);
			checkEqual(imemaddr, `RESET_PC + `PC_STEP * word_t'(i + 1), "sequential pc");
		end

		cycleCount = 0;
		while (cycleCount < RANDOM_CYCLES && !halted) begin
			randomCycle();
			cycleCount++;
		end

		// force the halt if random fetch never reached it
		if (!halted) begin
			runCycle(1'b1, XFER_JR, 32'h40, '0, haltAddr, '0);
			waitCount = 0;
			while (!halted && waitCount < HALT_TIMEOUT) begin
				runCycle(1'b0, XFER_NONE, '0, '0, '0, '0);
				waitCount++;
			end
			if (!halted) begin
				$display("halted did not rise within %0d cycles of a jr to the halt address",
					HALT_TIMEOUT);
				$display("Simulation failed");
				$fatal(1, "halt timeout");
			end
		end

		// nothing may move while strobes keep coming
		for (int i = 0; i < HELD_CYCLES; i++) begin
			randomCycle();
			checkEqual(word_t'(redirect), '0, "redirect while halted");
			checkEqual(imemaddr, haltAddr, "pc while halted");
		end

		if (redirectCount == 0) begin
			$display("the random stimulus never caused a redirect");
			$display("Simulation failed");
			$fatal(1, "no redirect exercised");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// ==== verification/fetchStage_checker.sv ====
// bound into fetchStage; exValid is taken as a one-cycle strobe, checks are off while rstN is low
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetchStage_checker import cpu_types_pkg::*; (
	input logic  CLK,
	input logic  rstN,
	input logic  exValid,      // strobe latched at this edge
	input logic  exLatchValid,
	input logic  redirect,
	input logic  halted,
	input logic  ifidValid,
	input word_t imemaddr
);

	// first edge out of reset still shows the reset state
	resetValues: assert property (@(posedge CLK) $rose(rstN) |->
		(imemaddr == `RESET_PC) && !redirect && !halted && !ifidValid && !exLatchValid)
		else $error("outputs were not at their reset values when reset was released");

	// one strobe gives one redirect cycle, a second needs a fresh strobe
	singleRedirect: assert property (@(posedge CLK) disable iff (!rstN)
		redirect && !exValid |=> !redirect)
		else $error("redirect stayed high without a new strobe");

	// sticky until reset
	haltSticky: assert property (@(posedge CLK) disable iff (!rstN) halted |=> halted)
		else $error("halted fell while reset was not asserted");

	// fetch frozen once halted
	haltFreeze: assert property (@(posedge CLK) disable iff (!rstN)
		halted |=> $stable(imemaddr))
		else $error("imemaddr moved while halted was set");

endmodule

bind fetchStage fetchStage_checker u_checker (
	.CLK          (CLK),
	.rstN         (rstN),
	.exValid      (exValid),
	.exLatchValid (exLatchValid),
	.redirect     (redirect),
	.halted       (halted),
	.ifidValid    (ifidValid),
	.imemaddr     (imemaddr)
);

// ==== verilog/fetchStage.sv ====
// fetch top; ID/EX bundle must be a one-cycle strobe, redirect lands two edges after it
`timescale 1ns/100ps

module fetchStage import cpu_types_pkg::*; (
	input  logic       CLK,
	input  logic       rstN,
	input  word_t      imemload,  // instruction at imemaddr
	input  logic       exValid,   // one-cycle strobe
	input  xferClass_t exClass,
	input  word_t      exPC,
	input  word_t      exInstr,
	input  word_t      rdat1,
	input  word_t      rdat2,
	output word_t      imemaddr,
	output word_t      ifidInstr,
	output word_t      ifidPC,
	output logic       ifidValid,
	output logic       redirect,
	output logic       halted
);

	exLatch_t   exD;
	exLatch_t   exQ;
	logic       exLatchValid; // latched op live for one cycle
	ifidLatch_t ifidD;
	ifidLatch_t ifidQ;
	logic       ifidLoad;
	logic       ifidFlush;
	logic       takeBranch;
	logic       takeJump;
	word_t      branchTarget;
	word_t      jumpTarget;

	// pack the ID/EX bundle
	assign exD = '{xClass: exClass, pc: exPC, instr: exInstr, rdat1: rdat1, rdat2: rdat2};

	// valid follows the strobe, so back-to-back ops each get one cycle
	stageReg #(.PAYLOAD(exLatch_t)) u_exReg (
		.CLK   (CLK),
		.rstN  (rstN),
		.load  (exValid),
		.flush (!exValid),
		.d     (exD),
		.q     (exQ),
		.valid (exLatchValid)
	);

	branchUnit u_branch (
		.latchValid   (exLatchValid),
		.xClass       (exQ.xClass),
		.instrPC      (exQ.pc),
		.instr        (exQ.instr),
		.rdat1        (exQ.rdat1),
		.rdat2        (exQ.rdat2),
		.takeBranch   (takeBranch),
		.branchTarget (branchTarget)
	);

	jumpUnit u_jump (
		.latchValid (exLatchValid),
		.xClass     (exQ.xClass),
		.instrPC    (exQ.pc),
		.instr      (exQ.instr),
		.rdat1      (exQ.rdat1),
		.takeJump   (takeJump),
		.jumpTarget (jumpTarget)
	);

	programCounter u_pc (
		.CLK          (CLK),
		.rstN         (rstN),
		.imemload     (imemload),
		.takeBranch   (takeBranch),
		.branchTarget (branchTarget),
		.takeJump     (takeJump),
		.jumpTarget   (jumpTarget),
		.pc           (imemaddr),
		.redirect     (redirect),
		.halted       (halted),
		.ifidLoad     (ifidLoad),
		.ifidFlush    (ifidFlush)
	);

	// fetched word with its address
	assign ifidD = '{instr: imemload, pc: imemaddr};

	stageReg #(.PAYLOAD(ifidLatch_t)) u_ifidReg (
		.CLK   (CLK),
		.rstN  (rstN),
		.load  (ifidLoad),
		.flush (ifidFlush),
		.d     (ifidD),
		.q     (ifidQ),
		.valid (ifidValid)
	);

	// unpack IF/ID for decode
	assign ifidInstr = ifidQ.instr;
	assign ifidPC    = ifidQ.pc;

endmodule

// ==== verilog/programCounter.sv ====
// pc and halt; no stall input, halt only clears through rstN and redirects stop once halted
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module programCounter import cpu_types_pkg::*; (
	input  logic  CLK,
	input  logic  rstN,
	input  word_t imemload,     // word fetched at pc this cycle
	input  logic  takeBranch,
	input  word_t branchTarget,
	input  logic  takeJump,
	input  word_t jumpTarget,
	output word_t pc,
	output logic  redirect,     // pc leaves the sequential path
	output logic  halted,       // sticky
	output logic  ifidLoad,     // pc advances this edge
	output logic  ifidFlush     // kill the word in IF/ID
);

	word_t nextPC;
	word_t incPC;
	logic  haltFetch;
	logic  haltHit;

	assign incPC = pc + `PC_STEP;

	// halt word on the bus
	assign haltFetch = (imemload == `HALT_WORD);

	// strobes are dead once halted
	assign redirect = (takeJump || takeBranch) && !halted;

	// halt only counts when nothing redirects this cycle
	assign haltHit = haltFetch && !redirect && !halted;

	// next pc, jump over branch, any redirect over halt
	always_comb begin
		if (halted) begin
			nextPC = pc; // frozen
		end else if (takeJump) begin
			nextPC = jumpTarget;
		end else if (takeBranch) begin
			nextPC = branchTarget;
		end else if (haltFetch) begin
			nextPC = pc; // hold at the halt word
		end else begin
			nextPC = incPC;
		end
	end

	// pc register
	always_ff @(posedge CLK, negedge rstN) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else begin
			pc <= nextPC;
		end
	end

	// halt flag, set once, cleared only by reset
	always_ff @(posedge CLK, negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (haltHit) begin
			halted <= 1'b1;
		end
	end

	// IF/ID controls
	// a redirect edge loads and flushes, the flush wins in the latch
	assign ifidLoad  = redirect || (!halted && !haltFetch);
	assign ifidFlush = redirect;

endmodule

// ==== verilog/jumpUnit.sv ====
// j and jr targets; no link register write, jal is not supported here
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module jumpUnit import cpu_types_pkg::*; (
	input  logic       latchValid, // ID/EX latch holds a live op
	input  xferClass_t xClass,
	input  word_t      instrPC,
	input  word_t      instr,
	input  word_t      rdat1,      // jr destination
	output logic       takeJump,
	output word_t      jumpTarget
);

	logic  isJ;
	logic  isJr;
	word_t incPC;
	word_t regionTarget;

	// class decode
	assign isJ  = (xClass == XFER_J);
	assign isJr = (xClass == XFER_JR);

	// region bits come from pc+4, not the jump's own pc
	assign incPC = instrPC + `PC_STEP;

	// upper pc bits joined with the word index
	assign regionTarget = {incPC[`WORD_W-1 -: REGION_W],
		instr[INDEX_W-1:0], {`ADDR_SHIFT{1'b0}}};

	// jr uses the register, j the concatenation
	always_comb begin
		if (isJr) begin
			jumpTarget = rdat1;
		end else begin
			jumpTarget = regionTarget;
		end
	end

	// any live jump redirects, no condition
	assign takeJump = latchValid && (isJ || isJr);

endmodule

// ==== verilog/branchUnit.sv ====
// beq/bne resolution; purely combinational, result is only meaningful while latchValid is set
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module branchUnit import cpu_types_pkg::*; (
	input  logic       latchValid,  // ID/EX latch holds a live op
	input  xferClass_t xClass,
	input  word_t      instrPC,     // pc of the branch itself
	input  word_t      instr,
	input  word_t      rdat1,
	input  word_t      rdat2,
	output logic       takeBranch,
	output word_t      branchTarget
);

	logic  isBeq;
	logic  isBne;
	logic  opsEqual;
	word_t incPC;
	word_t offset;

	// class decode
	assign isBeq = (xClass == XFER_BEQ);
	assign isBne = (xClass == XFER_BNE);

	// operand compare, the only thing a branch needs from the regfile
	assign opsEqual = (rdat1 == rdat2);

	// pc of the following instruction
	assign incPC = instrPC + `PC_STEP;

	// sign extend imm16, then word to byte address
	assign offset = {{(`WORD_W - IMM_W - `ADDR_SHIFT){instr[IMM_W-1]}},
		instr[IMM_W-1:0], {`ADDR_SHIFT{1'b0}}};

	// taken target, relative to pc+4
	assign branchTarget = incPC + offset;

	// beq on equal, bne on not equal
	always_comb begin
		takeBranch = 1'b0;
		if (latchValid) begin
			if (isBeq) begin
				takeBranch = opsEqual;
			end else if (isBne) begin
				takeBranch = !opsEqual; // bne inverts the compare
			end
		end
	end

endmodule

// ==== verilog/stageReg.sv ====
// pipeline latch; flush beats load, payload has no reset so only valid is trustworthy after reset
`timescale 1ns/100ps

module stageReg #(
	parameter type PAYLOAD = logic [31:0]
) (
	input  logic   CLK,
	input  logic   rstN,
	input  logic   load,  // capture d, mark valid
	input  logic   flush, // drop valid
	input  PAYLOAD d,
	output PAYLOAD q,
	output logic   valid
);

	// payload register
	always_ff @(posedge CLK) begin
		if (load) begin
			q <= d; // captured even when flushed, valid says it is dead
		end
	end

	// valid bit, flush wins over load
	always_ff @(posedge CLK, negedge rstN) begin
		if (!rstN) begin
			valid <= 1'b0;
		end else if (flush) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end
	end

endmodule

// ==== verilog/cpu_types_pkg.sv ====
// shared fetch types; packed struct layouts are fixed, so latch widths change with `WORD_W
`include "fetch_cfg.svh"

package cpu_types_pkg;

	// one instruction or address
	typedef logic [`WORD_W-1:0] word_t;

	// class of the control-transfer op at ID/EX
	// decode resolves it before it reaches fetch
	typedef enum logic [2:0] {
		XFER_NONE = 3'd0, // not a control transfer
		XFER_BEQ  = 3'd1, // branch if rdat1 == rdat2
		XFER_BNE  = 3'd2, // branch if rdat1 != rdat2
		XFER_J    = 3'd3, // pc-region jump by 26-bit index
		XFER_JR   = 3'd4  // jump to register rdat1
	} xferClass_t;

	// ID/EX control latch payload
	// 3 + 4 * 32 = 131 bits
	typedef struct packed {
		xferClass_t xClass; // transfer class
		word_t      pc;     // address of the transfer op
		word_t      instr;  // raw instruction word
		word_t      rdat1;  // first register operand
		word_t      rdat2;  // second register operand
	} exLatch_t;

	// IF/ID latch payload
	// 64 bits, instruction above its address
	typedef struct packed {
		word_t instr; // fetched word
		word_t pc;    // address it came from
	} ifidLatch_t;

	// branch offset field width in the i-type word
	localparam int IMM_W = 16;

	// jump index field width in the j-type word
	localparam int INDEX_W = 26;

	// pc bits kept by a j target
	localparam int REGION_W = 4;

endpackage

// ==== verilog/fetch_cfg.svh ====
// fetch constants; pc step and halt word assume 32-bit words and word-aligned fetch only
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// datapath word width
// every word_t in the package is sized from this
`define WORD_W 32

// pc loaded while rstN is low
`define RESET_PC 32'h0000_0000

// fetched word that stops the pc
// all ones is not a legal encoding in the supported subset
`define HALT_WORD 32'hFFFF_FFFF

// sequential increment
// one instruction is four bytes
`define PC_STEP 32'd4

// branch offset and jump index shift
// word addressing into byte addresses
`define ADDR_SHIFT 2

`endif
